// ==== all.f ====
source/uart_line_pkg.sv
source/uart_cmd_pkg.sv
source/uart_tx_frame.sv
source/uart_rx_frame.sv
source/uart_cmd_ctrl.sv
source/uart_cmd_top.sv
tests/uart_cmd_assertions.sv
tests/uart_cmd_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= uart_cmd_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Test completed successfully
SOURCES   := $(wildcard source/*.sv tests/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/uart_cmd_tb.sv ====
`timescale 1ns/1ps

module uart_cmd_tb;

  import uart_line_pkg::*;
  import uart_cmd_pkg::*;

  localparam int TB_BAUD_DIV = 16;
  localparam int N_ROWS      = 8;
  localparam int FRAME_CYC   = FRAME_BITS * TB_BAUD_DIV;

  typedef struct packed {
    cmd_t       cmd;
    line_byte_t rsp;       // Returned by the responder on reads.
    logic       bad_par;
    logic       bad_stop;
    logic       silent;
  } row_t;

  // Row kinds as {wr, bad_par, bad_stop, silent}.
  localparam logic [3:0] ROW_KIND [N_ROWS] = '{
    4'b1000, 4'b0000, 4'b1000, 4'b0100, 4'b0010, 4'b0001, 4'b0000, 4'b1000
  };

  logic       clk;
  logic       rst_n;
  cmd_t       cmd;
  logic       cmd_vld;
  logic       cmd_rdy;
  rsp_t       read_rsp;
  logic       read_rdy;
  logic       rx;
  logic       tx;
  row_t       rows [N_ROWS];
  line_byte_t tx_bytes [$];  // Frames seen on tx.
  int         tx_gaps [$];   // Idle cycles before each frame.
  int         errors = 0;
  int         checks = 0;
  logic       aborted = 1'b0;

  uart_cmd_top #(.BAUD_DIV(TB_BAUD_DIV)) uart_cmd_top_i (
    .clk, .rst_n, .cmd, .cmd_vld, .cmd_rdy, .read_rsp, .read_rdy, .rx, .tx
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected)
    else
    begin
      $display("** Error at %0t: %s expected 'h%0h, got 'h%0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic wait_cmd_rdy(input int limit);
    for (int n = 0; n < limit && !cmd_rdy; n++)
      @(negedge clk);
    if (!cmd_rdy)
    begin
      $display("Timed out at %0t waiting for cmd_rdy", $time);
      errors++;
      aborted = 1'b1;
    end
  endtask

  // One response frame on rx, LSB first.
  task automatic drive_rsp_frame(input line_byte_t data, input logic bad_par,
                                 input logic bad_stop);
    logic [FRAME_BITS-1:0] bits;
    bits = {~bad_stop, (~^data) ^ bad_par, data, 1'b0};
    for (int i = 0; i < FRAME_BITS; i++)
    begin
      @(posedge clk);
      #1 rx = bits[i];
      repeat (TB_BAUD_DIV - 1) @(posedge clk);
    end
    @(posedge clk);
    #1 rx = 1'b1;
  endtask

  // Line monitor, samples tx at mid-bit on the falling edge.
  initial
  begin
    line_byte_t data;
    int         idle;
    idle = 0;
    forever
    begin
      @(negedge clk);
      if (rst_n && !tx)
      begin
        repeat (TB_BAUD_DIV / 2) @(negedge clk);
        check_value("tx start bit", 0, 32'(tx));
        for (int i = 0; i < DATA_BITS; i++)
        begin
          repeat (TB_BAUD_DIV) @(negedge clk);
          data[i] = tx;
        end
        repeat (TB_BAUD_DIV) @(negedge clk);
        check_value("tx parity bit", 32'(~^data), 32'(tx));
        repeat (TB_BAUD_DIV) @(negedge clk);
        check_value("tx stop bit", 1, 32'(tx));
        tx_bytes.push_back(data);
        tx_gaps.push_back(idle);
        idle = 1 - TB_BAUD_DIV / 2;  // Rest of the stop bit is not idle.
      end
      else
        idle++;
    end
  end

  initial
  begin
    row_t        r;
    rsp_t        rsp;
    line_byte_t  hi;
    line_byte_t  lo;
    int          gap;
    logic [31:0] seed;
    rst_n   = 1'b0;
    cmd     = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    seed    = 32'hcba0;
    for (int i = 0; i < N_ROWS; i++)
    begin
      seed    = xorshift(seed);
      rows[i] = '{cmd: '{wr: ROW_KIND[i][3], addr: seed[14:8], data: seed[7:0]},
                  rsp: seed[23:16], bad_par: ROW_KIND[i][2],
                  bad_stop: ROW_KIND[i][1], silent: ROW_KIND[i][0]};
    end
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    check_value("tx", 1, 32'(tx));
    check_value("cmd_rdy", 1, 32'(cmd_rdy));
    check_value("read_rdy", 0, 32'(read_rdy));
    for (int i = 0; i < N_ROWS && !aborted; i++)
    begin
      r = rows[i];
      wait_cmd_rdy(FRAME_CYC);
      if (aborted)
        break;
      @(posedge clk);
      #1 cmd = r.cmd;
      cmd_vld = 1'b1;
      @(posedge clk);
      #1 cmd_vld = 1'b0;
      check_value("cmd_rdy after accept", 0, 32'(cmd_rdy));
      @(posedge clk);
      #1 cmd = ~r.cmd;  // Strobe while busy.
      cmd_vld = 1'b1;
      @(posedge clk);
      #1 cmd_vld = 1'b0;
      if (r.cmd.wr)
      begin
        wait_cmd_rdy(3 * FRAME_CYC + GAP_CYCLES);
        check_value("frames per write", 2, tx_bytes.size());
        if (tx_bytes.size() != 2)
          aborted = 1'b1;
        else
        begin
          hi  = tx_bytes.pop_front();
          lo  = tx_bytes.pop_front();
          gap = tx_gaps[1];
          tx_gaps.delete();
          check_value("write frame 1", 32'({1'b1, r.cmd.addr}), 32'(hi));
          check_value("write frame 2", 32'(r.cmd.data), 32'(lo));
          checks++;
          assert (gap >= GAP_CYCLES)
          else
          begin
            $display("** Error at %0t: write gap expected >= %0d, got %0d",
                     $time, GAP_CYCLES, gap);
            errors++;
          end
        end
      end
      else
      begin
        for (int n = 0; n < 2 * FRAME_CYC && tx_bytes.size() == 0; n++)
          @(negedge clk);
        if (tx_bytes.size() == 0)
        begin
          $display("Timed out at %0t waiting for the read request frame", $time);
          errors++;
          aborted = 1'b1;
          break;
        end
        hi = tx_bytes.pop_front();
        tx_gaps.delete();
        check_value("read frame", 32'({1'b0, r.cmd.addr}), 32'(hi));
        fork
          begin
            repeat (2 * TB_BAUD_DIV) @(posedge clk);
            if (!r.silent)
              drive_rsp_frame(r.rsp, r.bad_par, r.bad_stop);
          end
          begin
            for (int n = 0; n < 2 * RSP_TIMEOUT_BITS * TB_BAUD_DIV && !read_rdy; n++)
              @(negedge clk);
            rsp = read_rsp;
            if (!read_rdy)
            begin
              $display("Timed out at %0t waiting for read_rdy", $time);
              errors++;
              aborted = 1'b1;
            end
            else
              check_value("cmd_rdy with read_rdy", 1, 32'(cmd_rdy));
          end
        join
        check_value("read_rsp.data", r.silent ? 32'h0 : 32'(r.rsp), 32'(rsp.data));
        check_value("read_rsp.parity_err", 32'(r.bad_par & !r.silent), 32'(rsp.parity_err));
        check_value("read_rsp.stop_err", 32'(r.bad_stop & !r.silent), 32'(rsp.stop_err));
        check_value("read_rsp.timeout", 32'(r.silent), 32'(rsp.timeout));
      end
    end
    if (!aborted)
    begin
      repeat (2 * FRAME_CYC) @(negedge clk);
      check_value("extra frames on tx", 0, tx_bytes.size());
    end
    errors += uart_cmd_top_i.uart_cmd_ctrl_i.uart_cmd_assertions_i.fail_count;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== tests/uart_cmd_assertions.sv ====
`timescale 1ns/1ps

module uart_cmd_assertions (
  input logic clk,
  input logic rst_n,
  input logic cmd_rdy,
  input logic read_rdy,
  input logic tx_start,
  input logic tx_done,
  input logic rx_arm
);

  int   fail_count = 0;
  logic in_frame;  // Between tx_start and tx_done.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      in_frame <= 1'b0;
    else if (tx_start)
      in_frame <= 1'b1;
    else if (tx_done)
      in_frame <= 1'b0;
  end

  read_rdy_single: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
  else
  begin
    $error("read_rdy was high for two cycles in a row");
    fail_count++;
  end

  tx_start_idle: assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !in_frame)
  else
  begin
    $error("tx_start pulsed while a frame was in progress");
    fail_count++;
  end

  // Receiver is only armed while a command is running.
  rx_arm_busy: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> !rx_arm)
  else
  begin
    $error("rx_arm was high while cmd_rdy was high");
    fail_count++;
  end

endmodule

bind uart_cmd_ctrl uart_cmd_assertions uart_cmd_assertions_i (
  .clk, .rst_n, .cmd_rdy, .read_rdy, .tx_start, .tx_done, .rx_arm
);

// ==== source/uart_cmd_top.sv ====
`timescale 1ns/1ps

module uart_cmd_top #(
  parameter int BAUD_DIV = uart_line_pkg::BAUD_DIV
) (
  input  logic               clk,
  input  logic               rst_n,
  input  uart_cmd_pkg::cmd_t cmd,
  input  logic               cmd_vld,
  output logic               cmd_rdy,
  output uart_cmd_pkg::rsp_t read_rsp,
  output logic               read_rdy,
  input  logic               rx,
  output logic               tx
);

  import uart_line_pkg::*;

  logic       tx_start;
  line_byte_t tx_byte;
  logic       tx_done;
  logic       rx_arm;
  logic       rx_busy;
  logic       rx_done;
  line_byte_t rx_byte;
  logic       rx_parity_err;
  logic       rx_stop_err;

  uart_cmd_ctrl #(.BAUD_DIV(BAUD_DIV)) uart_cmd_ctrl_i (
    .clk, .rst_n, .cmd, .cmd_vld, .cmd_rdy, .read_rsp, .read_rdy,
    .tx_start, .tx_byte, .tx_done,
    .rx_arm, .rx_busy, .rx_done, .rx_byte, .rx_parity_err, .rx_stop_err
  );

  uart_tx_frame #(.BAUD_DIV(BAUD_DIV)) uart_tx_frame_i (
    .clk, .rst_n, .tx_start, .tx_byte, .tx, .tx_done
  );

  uart_rx_frame #(.BAUD_DIV(BAUD_DIV)) uart_rx_frame_i (
    .clk, .rst_n, .rx, .rx_arm, .rx_busy, .rx_done,
    .rx_byte, .rx_parity_err, .rx_stop_err
  );

endmodule

// ==== source/uart_cmd_ctrl.sv ====
`timescale 1ns/1ps

module uart_cmd_ctrl #(
  parameter int BAUD_DIV = uart_line_pkg::BAUD_DIV
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  uart_cmd_pkg::cmd_t        cmd,
  input  logic                      cmd_vld,
  output logic                      cmd_rdy,
  output uart_cmd_pkg::rsp_t        read_rsp,
  output logic                      read_rdy,
  output logic                      tx_start,
  output uart_line_pkg::line_byte_t tx_byte,
  input  logic                      tx_done,
  output logic                      rx_arm,
  input  logic                      rx_busy,
  input  logic                      rx_done,
  input  uart_line_pkg::line_byte_t rx_byte,
  input  logic                      rx_parity_err,
  input  logic                      rx_stop_err
);

  import uart_line_pkg::*;
  import uart_cmd_pkg::*;

  localparam int TMO_CYCLES = RSP_TIMEOUT_BITS * BAUD_DIV;
  localparam int TMO_W      = $clog2(TMO_CYCLES);
  localparam int GAP_W      = $clog2(GAP_CYCLES);

  typedef enum logic [2:0] {IDLE, SEND_HI, GAP, SEND_LO, WAIT_RSP, REPORT} state_t;

  state_t           state;
  cmd_t             cmd_q;
  logic [GAP_W-1:0] gap_cnt;
  logic [TMO_W-1:0] tmo_cnt;
  logic             accept;
  logic             tmo_hit;

  // REPORT already frees the host for the next command.
  assign cmd_rdy  = (state == IDLE) || (state == REPORT);
  assign read_rdy = (state == REPORT);
  assign rx_arm   = (state == WAIT_RSP);
  assign accept   = cmd_rdy && cmd_vld;
  assign tmo_hit  = rx_arm && !rx_busy && (tmo_cnt == TMO_W'(TMO_CYCLES - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      tx_start <= 1'b0;
      gap_cnt  <= '0;
      tmo_cnt  <= '0;
    end
    else
    begin
      tx_start <= 1'b0;
      case (state)
        IDLE, REPORT:
        begin
          if (accept)
          begin
            state    <= SEND_HI;
            tx_start <= 1'b1;
          end
          else
            state <= IDLE;
        end
        SEND_HI:
        begin
          if (tx_done && cmd_q.wr)
          begin
            state   <= GAP;
            gap_cnt <= '0;
          end
          else if (tx_done)
          begin
            state   <= WAIT_RSP;
            tmo_cnt <= '0;
          end
        end
        GAP:
        begin
          if (gap_cnt == GAP_W'(GAP_CYCLES - 1))
          begin
            state    <= SEND_LO;
            tx_start <= 1'b1;
          end
          else
            gap_cnt <= gap_cnt + 1'b1;
        end
        SEND_LO:
          if (tx_done)
            state <= IDLE;
        WAIT_RSP:
        begin
          if (rx_done || tmo_hit)
            state <= REPORT;
          else if (rx_busy)
            tmo_cnt <= '0;  // Rearm after a false start.
          else
            tmo_cnt <= tmo_cnt + 1'b1;
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q   <= cmd;
      tx_byte <= {cmd.wr, cmd.addr};
    end
    else if (state == GAP)
      tx_byte <= cmd_q.data;
    if (rx_arm && rx_done)
      read_rsp <= '{data: rx_byte, parity_err: rx_parity_err,
                    stop_err: rx_stop_err, timeout: 1'b0};
    else if (tmo_hit)
      read_rsp <= '{data: '0, parity_err: 1'b0, stop_err: 1'b0, timeout: 1'b1};
  end

endmodule

// ==== source/uart_rx_frame.sv ====
`timescale 1ns/1ps

module uart_rx_frame #(
  parameter int BAUD_DIV = uart_line_pkg::BAUD_DIV
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      rx,
  input  logic                      rx_arm,
  output logic                      rx_busy,
  output logic                      rx_done,
  output uart_line_pkg::line_byte_t rx_byte,
  output logic                      rx_parity_err,
  output logic                      rx_stop_err
);

  import uart_line_pkg::*;

  localparam int CNT_W = $clog2(BAUD_DIV);
  localparam int IDX_W = $clog2(FRAME_BITS);

  logic [1:0]       rx_sync;
  logic             rx_s;
  logic [CNT_W-1:0] baud_cnt;
  logic [IDX_W-1:0] bit_idx;  // 0 is the start bit.
  logic             par_q;
  logic             sample;

  assign rx_s   = rx_sync[1];
  assign sample = rx_busy && (baud_cnt == '0);  // Mid-bit.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rx_sync <= 2'b11;
    else
      rx_sync <= {rx_sync[0], rx};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_busy       <= 1'b0;
      rx_done       <= 1'b0;
      baud_cnt      <= '0;
      bit_idx       <= '0;
      rx_parity_err <= 1'b0;
      rx_stop_err   <= 1'b0;
    end
    else
    begin
      rx_done <= 1'b0;
      if (!rx_busy)
      begin
        if (rx_arm && !rx_s)
        begin
          // Line fell, wait half a bit to confirm the start.
          rx_busy  <= 1'b1;
          baud_cnt <= CNT_W'(BAUD_DIV / 2 - 1);
          bit_idx  <= '0;
        end
      end
      else if (baud_cnt != '0)
        baud_cnt <= baud_cnt - 1'b1;
      else
      begin
        baud_cnt <= CNT_W'(BAUD_DIV - 1);
        bit_idx  <= bit_idx + 1'b1;
        if (bit_idx == '0 && rx_s)
          rx_busy <= 1'b0;  // False start.
        else if (bit_idx == IDX_W'(FRAME_BITS - 1))
        begin
          rx_busy       <= 1'b0;
          rx_done       <= 1'b1;
          rx_stop_err   <= !rx_s;
          rx_parity_err <= (par_q != ~^rx_byte);
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample && bit_idx >= IDX_W'(1) && bit_idx <= IDX_W'(DATA_BITS))
      rx_byte <= {rx_s, rx_byte[DATA_BITS-1:1]};  // LSB arrives first.
    if (sample && bit_idx == IDX_W'(DATA_BITS + 1))
      par_q <= rx_s;
  end

endmodule

// ==== source/uart_tx_frame.sv ====
`timescale 1ns/1ps

module uart_tx_frame #(
  parameter int BAUD_DIV = uart_line_pkg::BAUD_DIV
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      tx_start,
  input  uart_line_pkg::line_byte_t tx_byte,
  output logic                      tx,
  output logic                      tx_done
);

  import uart_line_pkg::*;

  localparam int CNT_W = $clog2(BAUD_DIV);
  localparam int IDX_W = $clog2(FRAME_BITS);

  logic                  busy;
  logic [CNT_W-1:0]      baud_cnt;  // Counts down to the end of a bit.
  logic [IDX_W-1:0]      bit_idx;
  logic [FRAME_BITS-2:0] shift_q;   // Data, parity and stop still to go.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b1;
      tx_done  <= 1'b0;
    end
    else
    begin
      tx_done <= 1'b0;
      if (!busy)
      begin
        if (tx_start)
        begin
          busy     <= 1'b1;
          baud_cnt <= CNT_W'(BAUD_DIV - 1);
          bit_idx  <= '0;
          tx       <= 1'b0;  // Start bit.
        end
      end
      else if (baud_cnt != '0)
        baud_cnt <= baud_cnt - 1'b1;
      else if (bit_idx == IDX_W'(FRAME_BITS - 1))
      begin
        // Stop bit done, line stays high.
        busy    <= 1'b0;
        tx_done <= 1'b1;
      end
      else
      begin
        baud_cnt <= CNT_W'(BAUD_DIV - 1);
        bit_idx  <= bit_idx + 1'b1;
        tx       <= shift_q[0];
      end
    end
  end

  // Odd parity: XNOR of the data bits.
  always_ff @(posedge clk)
  begin
    if (!busy && tx_start)
      shift_q <= {1'b1, ~^tx_byte, tx_byte};
    else if (busy && baud_cnt == '0)
      shift_q <= {1'b1, shift_q[FRAME_BITS-2:1]};
  end

endmodule

// ==== source/uart_cmd_pkg.sv ====
package uart_cmd_pkg;

  // Host register command, wr is bit 15.
  typedef struct packed {
    logic       wr;    // 1 for write, 0 for read.
    logic [6:0] addr;
    logic [7:0] data;  // Ignored on reads.
  } cmd_t;

  // Result of a read as seen by the host.
  typedef struct packed {
    uart_line_pkg::line_byte_t data;
    logic                      parity_err;
    logic                      stop_err;
    logic                      timeout;  // No response, data is zero.
  } rsp_t;

endpackage

// ==== source/uart_line_pkg.sv ====
package uart_line_pkg;

  // Serial line timing and framing.
  localparam int BAUD_DIV         = 434;  // Clock cycles per bit.
  localparam int DATA_BITS        = 8;
  localparam int FRAME_BITS       = 11;   // Start, data, parity and stop.

  // Idle cycles between the two frames of a write.
  localparam int GAP_CYCLES       = 100;

  // Bit times to wait for the start of a read response.
  localparam int RSP_TIMEOUT_BITS = 32;

  // Payload of one frame, sent LSB first.
  typedef logic [DATA_BITS-1:0] line_byte_t;

endpackage
